// File: Bender.yml
package:
  name: cpu_system

sources:
  - files:
      - verilog/cpuPkg.sv
      - verilog/busPkg.sv
      - verilog/memBusIf.sv
      - verilog/cpuAlu.sv
      - verilog/cpuControl.sv
      - verilog/cpuDatapath.sv
      - verilog/axiLiteHost.sv
      - verilog/memArbiter.sv
      - verilog/byteMemory.sv
      - verilog/cpuSystem.sv
  - target: test
    files:
      - tb/cpuSystemTb.sv

// File: compile.f
verilog/cpuPkg.sv
verilog/busPkg.sv
verilog/memBusIf.sv
verilog/cpuAlu.sv
verilog/cpuControl.sv
verilog/cpuDatapath.sv
verilog/axiLiteHost.sv
verilog/memArbiter.sv
verilog/byteMemory.sv
verilog/cpuSystem.sv
tb/cpuSystemTb.sv

// File: tb/cpuSystemTb.sv
`timescale 1ns/1ns

module cpuSystemTb;
	import busPkg::*;

	localparam int maxTests = 16;
	localparam int maxBytes = 32;
	localparam int pollLimit = 200;
	localparam int cyclesPerTest = 4000;
	// AXI OKAY response
	localparam logic [1:0] okayResp = 2'b00;

	logic clk;
	logic nRESET;
	logic run;
	logic awvalid;
	logic awready;
	logic [31:0] awaddr;
	logic wvalid;
	logic wready;
	logic [31:0] wdata;
	logic [3:0] wstrb;
	logic bvalid;
	logic bready;
	logic [1:0] bresp;
	logic arvalid;
	logic arready;
	logic [31:0] araddr;
	logic rvalid;
	logic rready;
	logic [31:0] rdata;
	logic [1:0] rresp;

	// One record per test line of the data file
	string testName [maxTests];
	logic isMemTest [maxTests];
	int memCount [maxTests];
	logic [15:0] startAddr [maxTests];
	int progLen [maxTests];
	logic [7:0] progByte [maxTests][maxBytes];
	logic [15:0] resultAddr [maxTests];
	logic [7:0] expected [maxTests];
	int testCount;
	logic loaded;
	logic [31:0] seed;
	int okCount;
	int failCount;
	int respErrors;
	string respNote;
	// Expected memory contents by wrapped address
	logic [7:0] model [memDepth];

	cpuSystem u_dut (
		.clk(clk), .nRESET(nRESET), .run(run),
		.awvalid(awvalid), .awready(awready), .awaddr(awaddr),
		.wvalid(wvalid), .wready(wready), .wdata(wdata), .wstrb(wstrb),
		.bvalid(bvalid), .bready(bready), .bresp(bresp),
		.arvalid(arvalid), .arready(arready), .araddr(araddr),
		.rvalid(rvalid), .rready(rready), .rdata(rdata), .rresp(rresp)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	function automatic logic [31:0] lcgNext(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	task automatic loadTests();
		int fd;
		int n;
		int i;
		string tok;
		string nameTok;
		string rest;
		logic [31:0] val;
		testCount = 0;
		fd = $fopen("tb/programs_input.txt", "r");
		if (fd == 0) begin
			$display("cannot open tb/programs_input.txt");
		end else begin
			while ($fscanf(fd, "%s", tok) == 1) begin
				if (tok.substr(0, 0) == "#") begin
					n = $fgets(rest, fd);
				end else if (testCount < maxTests) begin
					n = $fscanf(fd, "%s", nameTok);
					testName[testCount] = nameTok;
					isMemTest[testCount] = (tok == "mem");
					if (tok == "mem") begin
						n = $fscanf(fd, "%d", memCount[testCount]);
					end else begin
						n = $fscanf(fd, "%h", val);
						startAddr[testCount] = val[15:0];
						n = $fscanf(fd, "%d", progLen[testCount]);
						for (i = 0; i < progLen[testCount]; i++) begin
							n = $fscanf(fd, "%h", val);
							if (i < maxBytes)
								progByte[testCount][i] = val[7:0];
						end
						if (progLen[testCount] > maxBytes)
							progLen[testCount] = maxBytes;
						n = $fscanf(fd, "%h", val);
						resultAddr[testCount] = val[15:0];
						n = $fscanf(fd, "%h", val);
						expected[testCount] = val[7:0];
					end
					testCount++;
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic pulseReset();
		nRESET <= 1'b0;
		repeat (2) @(posedge clk);
		nRESET <= 1'b1;
		@(posedge clk);
	endtask

	// Keeps the first bus protocol mismatch of the running test
	task automatic recordMismatch(input string what, input logic [1:0] exp,
		input logic [1:0] act);
		if (respErrors == 0)
			respNote = $sformatf("%s expected %0h actual %0h", what, exp, act);
		respErrors++;
	endtask

	// Address and data offered together, then wait for the write response
	task automatic axiWrite(input logic [31:0] addr, input logic [7:0] data);
		awvalid <= 1'b1;
		awaddr <= addr;
		wvalid <= 1'b1;
		wdata <= {24'h000000, data};
		do @(posedge clk); while (!awready);
		if (wready !== 1'b1)
			recordMismatch("wready", 2'b01, {1'b0, wready});
		awvalid <= 1'b0;
		wvalid <= 1'b0;
		bready <= 1'b1;
		do @(posedge clk); while (!bvalid);
		if (bresp !== okayResp)
			recordMismatch("bresp", okayResp, bresp);
		bready <= 1'b0;
	endtask

	task automatic axiRead(input logic [31:0] addr, output logic [7:0] data);
		arvalid <= 1'b1;
		araddr <= addr;
		do @(posedge clk); while (!arready);
		arvalid <= 1'b0;
		rready <= 1'b1;
		do @(posedge clk); while (!rvalid);
		data = rdata[7:0];
		if (rresp !== okayResp)
			recordMismatch("rresp", okayResp, rresp);
		rready <= 1'b0;
	endtask

	task automatic checkReadback(input int t);
		logic [15:0] addrQ [$];
		logic [15:0] addr;
		logic [15:0] aliasAddr;
		logic [15:0] badAddr;
		logic [7:0] data;
		logic [7:0] got;
		logic [7:0] badExp;
		logic [7:0] badGot;
		int errors;
		int i;
		run <= 1'b0;
		pulseReset();
		errors = 0;
		respErrors = 0;
		for (i = 0; i < memCount[t]; i++) begin
			seed = lcgNext(seed);
			addr = seed[31:16];
			data = seed[15:8];
			model[addr % memDepth] = data;
			addrQ.push_back(addr);
			axiWrite({16'h0000, addr}, data);
		end
		// Each byte comes back through an alias one memory size higher
		for (i = 0; i < addrQ.size(); i++) begin
			aliasAddr = addrQ[i] + 16'(memDepth);
			axiRead({16'h0000, aliasAddr}, got);
			if (got !== model[addrQ[i] % memDepth]) begin
				if (errors == 0) begin
					badAddr = addrQ[i];
					badExp = model[addrQ[i] % memDepth];
					badGot = got;
				end
				errors++;
			end
		end
		if (errors != 0) begin
			$display("ERROR %s expected %02h actual %02h at address %04h",
				testName[t], badExp, badGot, badAddr);
			failCount++;
		end else if (respErrors != 0) begin
			$display("ERROR %s %s", testName[t], respNote);
			failCount++;
		end else begin
			$display("%s ok, %0d bytes", testName[t], addrQ.size());
			okCount++;
		end
	endtask

	task automatic runProgram(input int t);
		logic [15:0] addr;
		logic [7:0] prefill;
		logic [7:0] got;
		logic done;
		logic wrong;
		int polls;
		int i;
		run <= 1'b0;
		pulseReset();
		respErrors = 0;
		for (i = 0; i < progLen[t]; i++) begin
			addr = startAddr[t] + i[15:0];
			axiWrite({16'h0000, addr}, progByte[t][i]);
		end
		// Vector at the top of the address map lands on the wrapped bytes
		axiWrite(32'h0000FFFC, startAddr[t][7:0]);
		axiWrite(32'h0000FFFD, startAddr[t][15:8]);
		prefill = ~expected[t];
		axiWrite({16'h0000, resultAddr[t]}, prefill);
		run <= 1'b1;
		polls = 0;
		done = 1'b0;
		wrong = 1'b0;
		got = prefill;
		while (!done && polls < pollLimit) begin
			seed = lcgNext(seed);
			repeat (seed[17:16]) @(posedge clk);
			axiRead({16'h0000, resultAddr[t]}, got);
			polls++;
			if (got === expected[t]) begin
				done = 1'b1;
			end else if (got !== prefill) begin
				done = 1'b1;
				wrong = 1'b1;
			end
		end
		if (wrong) begin
			$display("ERROR %s expected %02h actual %02h", testName[t], expected[t], got);
			failCount++;
		end else if (!done) begin
			$display("%s never wrote its result to %04h within %0d polls",
				testName[t], resultAddr[t], pollLimit);
			failCount++;
		end else if (respErrors != 0) begin
			$display("ERROR %s %s", testName[t], respNote);
			failCount++;
		end else begin
			$display("%s ok after %0d polls", testName[t], polls);
			okCount++;
		end
	endtask

	initial begin
		int t;
		nRESET <= 1'b0;
		run <= 1'b0;
		awvalid <= 1'b0;
		awaddr <= 32'h0;
		wvalid <= 1'b0;
		wdata <= 32'h0;
		wstrb <= 4'hF;
		bready <= 1'b0;
		arvalid <= 1'b0;
		araddr <= 32'h0;
		rready <= 1'b0;
		seed = 32'h2137;
		okCount = 0;
		failCount = 0;
		respErrors = 0;
		respNote = "";
		loaded = 1'b0;
		loadTests();
		if (testCount == 0) begin
			$display("no tests found in tb/programs_input.txt");
			$display("test failed");
			$finish;
		end else begin
			loaded = 1'b1;
			@(posedge clk);
			for (t = 0; t < testCount; t++) begin
				if (isMemTest[t])
					checkReadback(t);
				else
					runProgram(t);
			end
			$display("summary: %0d tests, %0d ok, %0d failing", testCount, okCount, failCount);
			if (failCount == 0)
				$display("test passed");
			else
				$display("test failed");
			$finish;
		end
	end

	// Budget scales with the number of tests in the data file
	initial begin
		wait (loaded === 1'b1);
		repeat (testCount * cyclesPerTest) @(posedge clk);
		$display("watchdog stopped the run after %0d cycles", testCount * cyclesPerTest);
		$display("test failed");
		$finish;
	end

endmodule

// File: tb/programs_input.txt
# A memory test line holds mem, a name and the number of random write/read pairs
# A program line holds prog, a name, the start address, the byte count in decimal,
# the program bytes, the result address and the expected result byte, all in hex
mem memReadback 24
# LDA #5A then STA $0380 then JMP to itself
prog loadStore 0100 8 A9 5A 8D 80 03 4C 05 01 0380 5A
# LDA #FF, ADC #02, STA $0381, LDA #00, ADC #00, STA $0382, JMP to itself
prog adcCarryLo 0120 17 A9 FF 69 02 8D 81 03 A9 00 69 00 8D 82 03 4C 2E 01 0381 01
# Same program, second sum only comes out as 01 if the carry survived LDA
prog adcCarryHi 0120 17 A9 FF 69 02 8D 81 03 A9 00 69 00 8D 82 03 4C 2E 01 0382 01
# LDX #FF and INX twice so X wraps through 00 to 01, then STX $0383
prog xWrap 0140 10 A2 FF E8 E8 8E 83 03 4C 47 01 0383 01
# LDA $020B reads the trailing data byte 3C
# then TAX, INX and STX $0384
prog taxPath 0200 12 AD 0B 02 AA E8 8E 84 03 4C 08 02 3C 0384 3D
# NOP then STX $0385 with X still at its reset value
prog resetX 0160 7 EA 8E 85 03 4C 64 01 0385 00
# Long fetch stream while the host keeps polling
# LDX #F0, five INX, STX $0386, JMP to itself
prog contention 0180 13 A2 F0 E8 E8 E8 E8 E8 8E 86 03 4C 8A 01 0386 F5

// File: verilog/axiLiteHost.sv
`timescale 1ns/1ns

module axiLiteHost (
	input logic clk,
	input logic nRESET,
	input logic awvalid,
	output logic awready,
	input logic [31:0] awaddr,
	input logic wvalid,
	output logic wready,
	input logic [31:0] wdata,
	input logic [3:0] wstrb,
	output logic bvalid,
	input logic bready,
	output logic [1:0] bresp,
	input logic arvalid,
	output logic arready,
	input logic [31:0] araddr,
	output logic rvalid,
	input logic rready,
	output logic [31:0] rdata,
	output logic [1:0] rresp,
	memBusIf.master mem
);
	import busPkg::*;

	typedef enum logic [1:0] {idle, request, respond} hostStateT;

	hostStateT state;
	logic isRead;
	logic [memAddrWidth-1:0] addrReg;
	logic [7:0] wdataReg;
	logic [7:0] rdataReg;
	logic takeRead;
	logic takeWrite;

	// Read wins over a write offered in the same cycle
	assign takeRead = (state == idle) & arvalid;
	assign takeWrite = (state == idle) & ~arvalid & awvalid & wvalid;
	assign arready = takeRead;
	assign awready = takeWrite;
	assign wready = takeWrite;

	assign mem.req = (state == request);
	assign mem.reqData = '{addr: addrReg, wdata: wdataReg, write: ~isRead};

	assign bvalid = (state == respond) & ~isRead;
	assign bresp = axiRespOkay;
	assign rvalid = (state == respond) & isRead;
	assign rdata = {24'h000000, rdataReg};
	assign rresp = axiRespOkay;

	always_ff @(posedge clk) begin
		if (!nRESET) begin
			state <= idle;
			isRead <= 1'b0;
		end else begin
			case (state)
				idle: begin
					if (takeRead | takeWrite) begin
						state <= request;
						isRead <= takeRead;
					end
				end
				request: begin
					if (mem.ack)
						state <= respond;
				end
				respond: begin
					if ((bvalid & bready) | (rvalid & rready))
						state <= idle;
				end
				default: state <= idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (takeRead) begin
			addrReg <= araddr[memAddrWidth-1:0];
		end else if (takeWrite) begin
			addrReg <= awaddr[memAddrWidth-1:0];
			wdataReg <= wdata[7:0];
		end
		if (state == request && mem.ack && isRead)
			rdataReg <= mem.rdata;
	end

endmodule

// File: verilog/busPkg.sv
package busPkg;

	localparam int memAddrWidth = 16;

	// Only the low address bits are decoded, so addresses wrap
	localparam int memDepth = 1024;
	localparam int memIdxWidth = $clog2(memDepth);

	typedef struct packed {
		logic [memAddrWidth-1:0] addr;
		logic [7:0] wdata;
		logic write;
	} memReqT;

	localparam logic [1:0] axiRespOkay = 2'b00;

endpackage

// File: verilog/byteMemory.sv
`timescale 1ns/1ns

module byteMemory (
	input logic clk,
	memBusIf.memory port
);
	import busPkg::*;

	logic [7:0] mem [memDepth];
	logic [memIdxWidth-1:0] idx;

	// High address bits ignored, the array wraps
	assign idx = port.reqData.addr[memIdxWidth-1:0];

	always_ff @(posedge clk) begin
		port.ack <= port.gnt;
		if (port.gnt) begin
			if (port.reqData.write)
				mem[idx] <= port.reqData.wdata;
			port.rdata <= mem[idx];
		end
	end

endmodule

// File: verilog/cpuAlu.sv
`timescale 1ns/1ns

module cpuAlu (
	input cpuPkg::aluFuncT func,
	input logic [7:0] a,
	input logic [7:0] b,
	input logic carryIn,
	output logic [7:0] result,
	output logic carryOut,
	output logic zeroOut
);
	import cpuPkg::*;

	logic [8:0] sum;

	// Binary add only, no decimal correction
	assign sum = {1'b0, a} + {1'b0, b} + {8'h00, carryIn};

	always_comb begin
		result = b;
		carryOut = carryIn;
		case (func)
			aluPass: result = b;
			aluAdd: begin
				result = sum[7:0];
				carryOut = sum[8];
			end
			aluInc: result = a + 8'h01;
			default: result = b;
		endcase
	end

	assign zeroOut = (result == 8'h00);

endmodule

// File: verilog/cpuControl.sv
`timescale 1ns/1ns

module cpuControl (
	input logic clk,
	input logic nRESET,
	input logic run,
	input logic [7:0] dataIn,
	input logic memDone,
	output cpuPkg::addrSelT addrSel,
	output logic aEn,
	output logic xEn,
	output logic pcEn,
	output logic pcInc,
	output logic bufLoEn,
	output logic bufHiEn,
	output cpuPkg::aluFuncT aluFunc,
	output logic aluSrcX,
	output logic storeX,
	output logic memRead,
	output logic memWrite
);
	import cpuPkg::*;

	stepT step;
	stepT nextStep;
	logic [7:0] ir;
	logic stepGo;

	always_comb begin
		addrSel = pcSel;
		aEn = 1'b0;
		xEn = 1'b0;
		pcEn = 1'b0;
		pcInc = 1'b0;
		bufLoEn = 1'b0;
		bufHiEn = 1'b0;
		aluFunc = aluPass;
		aluSrcX = 1'b0;
		storeX = 1'b0;
		memRead = 1'b0;
		memWrite = 1'b0;
		nextStep = fetchOp;
		case (step)
			loadPcLo: begin
				addrSel = vectorSel;
				memRead = 1'b1;
				bufLoEn = 1'b1;
				nextStep = loadPcHi;
			end
			loadPcHi: begin
				addrSel = vectorSel;
				memRead = 1'b1;
				pcEn = 1'b1;
			end
			fetchOp: begin
				memRead = 1'b1;
				pcInc = 1'b1;
				// Opcode is decoded straight off the bypassed read data
				case (dataIn)
					opLdaImm, opLdxImm, opAdcImm: nextStep = fetchLo;
					opLdaAbs, opStaAbs, opStxAbs, opJmpAbs: nextStep = fetchLo;
					opTax, opInx: nextStep = execRead;
					default: nextStep = fetchOp;
				endcase
			end
			fetchLo: begin
				memRead = 1'b1;
				pcInc = 1'b1;
				case (ir)
					opLdaImm: aEn = 1'b1;
					opLdxImm: xEn = 1'b1;
					opAdcImm: begin
						aEn = 1'b1;
						aluFunc = aluAdd;
					end
					default: begin
						bufLoEn = 1'b1;
						nextStep = fetchHi;
					end
				endcase
			end
			fetchHi: begin
				memRead = 1'b1;
				if (ir == opJmpAbs) begin
					pcEn = 1'b1;
				end else begin
					pcInc = 1'b1;
					bufHiEn = 1'b1;
					nextStep = (ir == opLdaAbs) ? execRead : execWrite;
				end
			end
			execRead: begin
				case (ir)
					opLdaAbs: begin
						addrSel = bufferSel;
						memRead = 1'b1;
						aEn = 1'b1;
					end
					opInx: begin
						xEn = 1'b1;
						aluFunc = aluInc;
						aluSrcX = 1'b1;
					end
					// TAX, A passes through the ALU
					default: xEn = 1'b1;
				endcase
			end
			execWrite: begin
				addrSel = bufferSel;
				memWrite = 1'b1;
				storeX = (ir == opStxAbs);
			end
			default: nextStep = loadPcLo;
		endcase
	end

	// Memory steps wait for their ack
	assign stepGo = run & ((memRead | memWrite) ? memDone : 1'b1);

	always_ff @(posedge clk) begin
		if (!nRESET)
			step <= loadPcLo;
		else if (stepGo)
			step <= nextStep;
	end

	always_ff @(posedge clk) begin
		if (stepGo && step == fetchOp)
			ir <= dataIn;
	end

endmodule

// File: verilog/cpuDatapath.sv
`timescale 1ns/1ns

module cpuDatapath (
	input logic clk,
	input logic nRESET,
	input logic run,
	memBusIf.master mem,
	input cpuPkg::addrSelT addrSel,
	input logic aEn,
	input logic xEn,
	input logic pcEn,
	input logic pcInc,
	input logic bufLoEn,
	input logic bufHiEn,
	input cpuPkg::aluFuncT aluFunc,
	input logic aluSrcX,
	input logic storeX,
	input logic memRead,
	input logic memWrite,
	output logic [7:0] dataIn,
	output logic carry,
	output logic zero,
	output logic memDone
);
	import cpuPkg::*;
	import busPkg::*;

	logic [7:0] accA;
	logic [7:0] regX;
	logic [memAddrWidth-1:0] pc;
	logic [7:0] dinReg;
	logic [7:0] bufLo;
	logic [7:0] bufHi;
	logic [memAddrWidth-1:0] addrBus;
	logic [7:0] aluA;
	logic [7:0] aluB;
	logic [7:0] aluOut;
	logic aluCarry;
	logic aluZero;
	logic reqReg;
	logic stepGo;

	assign memDone = mem.ack;
	assign stepGo = run & ((memRead | memWrite) ? memDone : 1'b1);

	// Read data bypasses the register in the ack cycle
	assign dataIn = memDone ? mem.rdata : dinReg;

	always_comb begin
		case (addrSel)
			bufferSel: addrBus = {bufHi, bufLo};
			// pcEn marks the vector high byte step
			vectorSel: addrBus = resetVector + {15'd0, pcEn};
			default: addrBus = pc;
		endcase
	end

	// Request held from issue until ack, none started while halted
	always_ff @(posedge clk) begin
		if (!nRESET)
			reqReg <= 1'b0;
		else if (mem.ack)
			reqReg <= 1'b0;
		else if ((memRead | memWrite) & run)
			reqReg <= 1'b1;
	end

	assign mem.req = reqReg;
	assign mem.reqData = '{addr: addrBus, wdata: storeX ? regX : accA, write: memWrite};

	assign aluA = aluSrcX ? regX : accA;
	// Memory data on a read step, the accumulator otherwise
	assign aluB = memRead ? dataIn : accA;

	cpuAlu u_alu (
		.func(aluFunc),
		.a(aluA),
		.b(aluB),
		.carryIn(carry),
		.result(aluOut),
		.carryOut(aluCarry),
		.zeroOut(aluZero)
	);

	always_ff @(posedge clk) begin
		if (!nRESET) begin
			accA <= 8'h00;
			regX <= 8'h00;
			pc <= '0;
			carry <= 1'b0;
			zero <= 1'b0;
		end else if (stepGo) begin
			if (aEn)
				accA <= aluOut;
			if (xEn)
				regX <= aluOut;
			if (aEn | xEn) begin
				carry <= aluCarry;
				zero <= aluZero;
			end
			if (pcEn)
				pc <= {dataIn, bufLo};
			else if (pcInc)
				pc <= pc + 16'd1;
		end
	end

	always_ff @(posedge clk) begin
		if (memDone)
			dinReg <= mem.rdata;
		if (stepGo & bufLoEn)
			bufLo <= dataIn;
		if (stepGo & bufHiEn)
			bufHi <= dataIn;
	end

endmodule

// File: verilog/cpuPkg.sv
package cpuPkg;

	// Opcodes of the supported 6502 subset
	localparam logic [7:0] opLdaImm = 8'hA9;
	localparam logic [7:0] opLdaAbs = 8'hAD;
	localparam logic [7:0] opLdxImm = 8'hA2;
	localparam logic [7:0] opStaAbs = 8'h8D;
	localparam logic [7:0] opStxAbs = 8'h8E;
	localparam logic [7:0] opAdcImm = 8'h69;
	localparam logic [7:0] opTax = 8'hAA;
	localparam logic [7:0] opInx = 8'hE8;
	localparam logic [7:0] opJmpAbs = 8'h4C;

	// Microsteps of the control sequencer
	typedef enum logic [2:0] {
		fetchOp,
		fetchLo,
		fetchHi,
		execRead,
		execWrite,
		loadPcLo,
		loadPcHi
	} stepT;

	// Memory address source
	typedef enum logic [1:0] {pcSel, bufferSel, vectorSel} addrSelT;

	typedef enum logic [1:0] {aluPass, aluAdd, aluInc} aluFuncT;

	// Low byte of the reset vector, high byte follows
	localparam logic [15:0] resetVector = 16'hFFFC;

endpackage

// File: verilog/cpuSystem.sv
`timescale 1ns/1ns

module cpuSystem (
	input logic clk,
	input logic nRESET,
	input logic run,
	input logic awvalid,
	output logic awready,
	input logic [31:0] awaddr,
	input logic wvalid,
	output logic wready,
	input logic [31:0] wdata,
	input logic [3:0] wstrb,
	output logic bvalid,
	input logic bready,
	output logic [1:0] bresp,
	input logic arvalid,
	output logic arready,
	input logic [31:0] araddr,
	output logic rvalid,
	input logic rready,
	output logic [31:0] rdata,
	output logic [1:0] rresp
);
	import cpuPkg::*;

	addrSelT addrSel;
	aluFuncT aluFunc;
	logic aEn;
	logic xEn;
	logic pcEn;
	logic pcInc;
	logic bufLoEn;
	logic bufHiEn;
	logic aluSrcX;
	logic storeX;
	logic memRead;
	logic memWrite;
	logic [7:0] dataIn;
	logic memDone;

	memBusIf cpuBus ();
	memBusIf hostBus ();
	memBusIf memBus ();

	// Flags stay inside the core
	cpuDatapath u_datapath (
		.clk(clk),
		.nRESET(nRESET),
		.run(run),
		.mem(cpuBus),
		.addrSel(addrSel),
		.aEn(aEn),
		.xEn(xEn),
		.pcEn(pcEn),
		.pcInc(pcInc),
		.bufLoEn(bufLoEn),
		.bufHiEn(bufHiEn),
		.aluFunc(aluFunc),
		.aluSrcX(aluSrcX),
		.storeX(storeX),
		.memRead(memRead),
		.memWrite(memWrite),
		.dataIn(dataIn),
		.carry(),
		.zero(),
		.memDone(memDone)
	);

	cpuControl u_control (
		.clk(clk),
		.nRESET(nRESET),
		.run(run),
		.dataIn(dataIn),
		.memDone(memDone),
		.addrSel(addrSel),
		.aEn(aEn),
		.xEn(xEn),
		.pcEn(pcEn),
		.pcInc(pcInc),
		.bufLoEn(bufLoEn),
		.bufHiEn(bufHiEn),
		.aluFunc(aluFunc),
		.aluSrcX(aluSrcX),
		.storeX(storeX),
		.memRead(memRead),
		.memWrite(memWrite)
	);

	axiLiteHost u_host (
		.clk(clk),
		.nRESET(nRESET),
		.awvalid(awvalid),
		.awready(awready),
		.awaddr(awaddr),
		.wvalid(wvalid),
		.wready(wready),
		.wdata(wdata),
		.wstrb(wstrb),
		.bvalid(bvalid),
		.bready(bready),
		.bresp(bresp),
		.arvalid(arvalid),
		.arready(arready),
		.araddr(araddr),
		.rvalid(rvalid),
		.rready(rready),
		.rdata(rdata),
		.rresp(rresp),
		.mem(hostBus)
	);

	memArbiter #(.payloadT(busPkg::memReqT)) u_arbiter (
		.clk(clk),
		.nRESET(nRESET),
		.cpuPort(cpuBus),
		.hostPort(hostBus),
		.memPort(memBus)
	);

	byteMemory u_ram (
		.clk(clk),
		.port(memBus)
	);

endmodule

// File: verilog/memArbiter.sv
`timescale 1ns/1ns

module memArbiter #(
	parameter type payloadT = busPkg::memReqT
) (
	input logic clk,
	input logic nRESET,
	memBusIf.arbSlave cpuPort,
	memBusIf.arbSlave hostPort,
	memBusIf.arbMaster memPort
);

	logic busy;
	// Owner of the current transfer, also the master served last
	logic lastHost;
	logic grantCpu;
	logic grantHost;
	payloadT selData;

	// On a tie the master not served last goes first
	assign grantHost = ~busy & hostPort.req & (~cpuPort.req | ~lastHost);
	assign grantCpu = ~busy & cpuPort.req & ~grantHost;
	assign selData = grantHost ? hostPort.reqData : cpuPort.reqData;

	assign memPort.req = cpuPort.req | hostPort.req;
	assign memPort.gnt = grantCpu | grantHost;
	assign memPort.reqData = selData;

	assign cpuPort.gnt = grantCpu;
	assign hostPort.gnt = grantHost;
	assign cpuPort.ack = memPort.ack & ~lastHost;
	assign hostPort.ack = memPort.ack & lastHost;
	assign cpuPort.rdata = lastHost ? 8'h00 : memPort.rdata;
	assign hostPort.rdata = lastHost ? memPort.rdata : 8'h00;

	// Busy covers the ack cycle, so a held req is not granted twice
	always_ff @(posedge clk) begin
		if (!nRESET) begin
			busy <= 1'b0;
			lastHost <= 1'b0;
		end else if (memPort.gnt) begin
			busy <= 1'b1;
			lastHost <= grantHost;
		end else if (memPort.ack) begin
			busy <= 1'b0;
		end
	end

endmodule

// File: verilog/memBusIf.sv
`timescale 1ns/1ns

interface memBusIf;
	import busPkg::*;

	logic req;
	logic gnt;
	logic ack;
	memReqT reqData;
	logic [7:0] rdata;

	modport master(output req, output reqData, input gnt, input ack, input rdata);

	modport arbSlave(input req, input reqData, output gnt, output ack, output rdata);

	// Arbiter side facing the memory
	modport arbMaster(output req, output reqData, output gnt, input ack, input rdata);

	modport memory(input gnt, input reqData, output ack, output rdata);

endinterface
